/* sources.f */
+incdir+src
src/agc_pkg.sv
src/agc_reg_if.sv
src/agc_alu_if.sv
src/agc_ones_comp_alu.sv
src/agc_bank_translator.sv
src/agc_register_file.sv
src/agc_sequencer.sv
src/agc_core.sv
tests/agc_core_tb.sv

/* src/agc_alu_if.sv */
`timescale 1ns/1ns

interface agc_alu_if;
  import agc_pkg::*;

  // Operation select and operands
  alu_op_t op;
  word_t x;
  word_t y;

  // Combinational result
  word_t result;

  modport seq (
    output op, x, y,
    input result
  );

  modport alu (
    input op, x, y,
    output result
  );

endinterface : agc_alu_if

/* src/agc_bank_translator.sv */
`timescale 1ns/1ns
`include "agc_settings.svh"

module agc_bank_translator (
  input  agc_pkg::addr_t addr,
  input  agc_pkg::bank_t eb,
  input  agc_pkg::bank_t fb,
  output agc_pkg::rom_addr_t rom_addr,
  output agc_pkg::ram_addr_t ram_addr,
  output logic is_rom
);
  import agc_pkg::*;

  // Region decode
  logic in_fixed_fixed;
  logic in_erasable_bank;

  // Candidate translations
  rom_addr_t fixed_rom;
  rom_addr_t fb_offset;
  rom_addr_t switched_rom;
  ram_addr_t eb_offset;
  ram_addr_t erasable_ram;

  assign is_rom = addr >= addr_t'(`AGC_FIXED_SWITCH_BASE);
  assign in_fixed_fixed = addr >= addr_t'(`AGC_FIXED_FIXED_BASE);
  assign in_erasable_bank = addr >= addr_t'(`AGC_ERASABLE_BANK_BASE);

  // Fixed-fixed maps to the bottom of ROM
  assign fixed_rom = rom_addr_t'(addr - addr_t'(`AGC_FIXED_FIXED_BASE));

  // Switched fixed banks sit above fixed-fixed
  assign fb_offset = rom_addr_t'(fb) * rom_addr_t'(`AGC_FIXED_BANK_SIZE);
  assign switched_rom = rom_addr_t'(`AGC_FIXED_FIXED_BASE) + fb_offset
                      + rom_addr_t'(addr - addr_t'(`AGC_FIXED_SWITCH_BASE));

  // Erasable banks of 256 words each
  assign eb_offset = ram_addr_t'(eb) * ram_addr_t'(`AGC_ERASABLE_BANK_SIZE);
  assign erasable_ram = eb_offset
                      + ram_addr_t'(addr - addr_t'(`AGC_ERASABLE_BANK_BASE));

  // Unused side stays at zero
  always_comb begin
    rom_addr = '0;
    ram_addr = '0;
    if (in_fixed_fixed) begin
      rom_addr = fixed_rom;
    end else if (is_rom) begin
      rom_addr = switched_rom;
    end else if (in_erasable_bank) begin
      ram_addr = erasable_ram;
    end else begin
      // Unswitched erasable, below 1400 octal
      ram_addr = ram_addr_t'(addr);
    end
  end

endmodule : agc_bank_translator

/* src/agc_core.sv */
`timescale 1ns/1ns

module agc_core (
  input  logic clk,
  input  logic rst_l,
  input  logic cmd_valid,
  input  agc_pkg::cmd_op_t cmd_op,
  input  agc_pkg::reg_t cmd_reg,
  input  agc_pkg::word_t cmd_data,
  input  agc_pkg::addr_t cmd_addr,
  output logic rsp_valid,
  output agc_pkg::word_t rsp_data,
  output agc_pkg::rom_addr_t rom_addr,
  output agc_pkg::ram_addr_t ram_addr,
  output logic addr_is_rom
);
  import agc_pkg::*;

  // Translator request and result
  addr_t xlate_addr;
  rom_addr_t xlate_rom;
  ram_addr_t xlate_ram;
  logic xlate_is_rom;

  // Bank taps from the register file
  bank_t eb;
  bank_t fb;

  agc_reg_if reg_bus ();
  agc_alu_if alu_bus ();

  // Command decode and output registers
  agc_sequencer u_sequencer (
    .clk(clk),
    .rst_l(rst_l),
    .cmd_valid(cmd_valid),
    .cmd_op(cmd_op),
    .cmd_reg(cmd_reg),
    .cmd_data(cmd_data),
    .cmd_addr(cmd_addr),
    .reg_bus(reg_bus.seq),
    .alu_bus(alu_bus.seq),
    .xlate_addr(xlate_addr),
    .xlate_rom(xlate_rom),
    .xlate_ram(xlate_ram),
    .xlate_is_rom(xlate_is_rom),
    .rsp_valid(rsp_valid),
    .rsp_data(rsp_data),
    .rom_addr(rom_addr),
    .ram_addr(ram_addr),
    .addr_is_rom(addr_is_rom)
  );

  agc_register_file u_register_file (
    .clk(clk),
    .rst_l(rst_l),
    .bus(reg_bus.regs),
    .eb(eb),
    .fb(fb)
  );

  agc_ones_comp_alu u_alu (
    .bus(alu_bus.alu)
  );

  // Purely combinational, read side only
  agc_bank_translator u_bank_translator (
    .addr(xlate_addr),
    .eb(eb),
    .fb(fb),
    .rom_addr(xlate_rom),
    .ram_addr(xlate_ram),
    .is_rom(xlate_is_rom)
  );

endmodule : agc_core

/* src/agc_ones_comp_alu.sv */
`timescale 1ns/1ns

module agc_ones_comp_alu (
  agc_alu_if.alu bus
);
  import agc_pkg::*;

  // Shared adder inputs
  word_t add_a;
  word_t add_b;

  // First pass sum and its carry out
  word_t partial;
  logic carry;

  // Sum after end-around carry
  word_t sum;

  // Adder operand steering
  always_comb begin
    add_a = bus.x;
    add_b = bus.y;
    case (bus.op)
      // Subtract is add of the complement
      ALU_SU: add_b = ~bus.y;
      // Increment works on y alone
      ALU_INCR: add_a = word_t'(1);
      default: begin
      end
    endcase
  end

  assign {carry, partial} = add_a + add_b;

  // Carry folds back into bit 0
  // a second carry out cannot happen here
  assign sum = partial + word_t'(carry);

  // Result select
  // minus zero passes through untouched
  always_comb begin
    case (bus.op)
      ALU_AD, ALU_SU, ALU_INCR: bus.result = sum;
      ALU_AND: bus.result = bus.x & bus.y;
      ALU_OR: bus.result = bus.x | bus.y;
      ALU_XOR: bus.result = bus.x ^ bus.y;
      ALU_COM: bus.result = ~bus.y;
      default: bus.result = '0;
    endcase
  end

endmodule : agc_ones_comp_alu

/* src/agc_pkg.sv */
`include "agc_settings.svh"

package agc_pkg;

  // Data and address words
  typedef logic [`AGC_WORD_W-1:0] word_t;
  typedef logic [`AGC_ADDR_W-1:0] addr_t;
  typedef logic [`AGC_ROM_ADDR_W-1:0] rom_addr_t;
  typedef logic [`AGC_RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [`AGC_BANK_W-1:0] bank_t;

  // Central, bank, editing and timer registers
  // ZERO is a read-only constant
  typedef enum logic [3:0] {
    A, L, Q,
    EB, FB, BB,
    ZERO,
    CYR, SR, CYL, SL,
    TIME1, TIME2
  } reg_t;

  // Command port opcodes
  typedef enum logic [3:0] {
    CMD_WRITE, CMD_READ,
    CMD_AD, CMD_SU,
    CMD_AND, CMD_OR, CMD_XOR,
    CMD_COM, CMD_INCR,
    CMD_XLATE
  } cmd_op_t;

  // ALU operations, all ones' complement
  typedef enum logic [2:0] {
    ALU_AD, ALU_SU,
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_COM, ALU_INCR
  } alu_op_t;

endpackage : agc_pkg

/* src/agc_reg_if.sv */
`timescale 1ns/1ns

interface agc_reg_if;
  import agc_pkg::*;

  // Read port, combinational view of rd_sel
  reg_t rd_sel;
  word_t rd_data;

  // Accumulator tap, feeds the ALU x operand
  word_t acc;

  // Single write port
  // data is shaped inside the register file
  logic wr_en;
  reg_t wr_sel;
  word_t wr_data;

  modport seq (
    output rd_sel, wr_en, wr_sel, wr_data,
    input rd_data, acc
  );

  modport regs (
    input rd_sel, wr_en, wr_sel, wr_data,
    output rd_data, acc
  );

endinterface : agc_reg_if

/* src/agc_register_file.sv */
`timescale 1ns/1ns

module agc_register_file (
  input  logic clk,
  input  logic rst_l,
  agc_reg_if.regs bus,
  output agc_pkg::bank_t eb,
  output agc_pkg::bank_t fb
);
  import agc_pkg::*;

  // Central registers
  word_t reg_a;
  word_t reg_l;
  word_t reg_q;

  // Bank bits, shared by EB, FB and BB
  bank_t eb_bits;
  bank_t fb_bits;

  // Editing registers hold the already shifted word
  word_t reg_cyr;
  word_t reg_sr;
  word_t reg_cyl;
  word_t reg_sl;

  // Timers
  word_t reg_time1;
  word_t reg_time2;

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      reg_a <= '0;
      reg_l <= '0;
      reg_q <= '0;
      eb_bits <= '0;
      fb_bits <= '0;
      reg_cyr <= '0;
      reg_sr <= '0;
      reg_cyl <= '0;
      reg_sl <= '0;
      reg_time1 <= '0;
      reg_time2 <= '0;
    end else if (bus.wr_en) begin
      case (bus.wr_sel)
        A: reg_a <= bus.wr_data;
        L: reg_l <= bus.wr_data;
        Q: reg_q <= bus.wr_data;
        // Only the pertinent bank bits are kept
        EB: eb_bits <= bus.wr_data[11:9];
        FB: fb_bits <= bus.wr_data[14:12];
        BB: begin
          fb_bits <= bus.wr_data[14:12];
          eb_bits <= bus.wr_data[11:9];
        end
        // Rotate right
        CYR: reg_cyr <= {bus.wr_data[0], bus.wr_data[14:1]};
        // Arithmetic shift right, sign copied
        SR: reg_sr <= {bus.wr_data[14], bus.wr_data[14:1]};
        // Rotate left
        CYL: reg_cyl <= {bus.wr_data[13:0], bus.wr_data[14]};
        // Shift left, zero fill
        SL: reg_sl <= {bus.wr_data[13:0], 1'b0};
        TIME1: reg_time1 <= bus.wr_data;
        TIME2: reg_time2 <= bus.wr_data;
        // ZERO and unused codes
        default: begin
        end
      endcase
    end
  end

  // Read views
  always_comb begin
    case (bus.rd_sel)
      A: bus.rd_data = reg_a;
      L: bus.rd_data = reg_l;
      Q: bus.rd_data = reg_q;
      // Bank bits in their word positions
      EB: bus.rd_data = {3'd0, eb_bits, 9'd0};
      FB: bus.rd_data = {fb_bits, 12'd0};
      BB: bus.rd_data = {fb_bits, eb_bits, 9'd0};
      CYR: bus.rd_data = reg_cyr;
      SR: bus.rd_data = reg_sr;
      CYL: bus.rd_data = reg_cyl;
      SL: bus.rd_data = reg_sl;
      TIME1: bus.rd_data = reg_time1;
      TIME2: bus.rd_data = reg_time2;
      // ZERO reads as zero, as do unused codes
      default: bus.rd_data = '0;
    endcase
  end

  assign bus.acc = reg_a;

  // Bank taps for the translator
  assign eb = eb_bits;
  assign fb = fb_bits;

  // Write select comes from the sequencer decode
  a_known_wr_sel: assert property (@(posedge clk) disable iff (!rst_l)
    bus.wr_en |-> (!$isunknown(bus.wr_sel) && (bus.wr_sel <= TIME2)))
    else $error("write with unknown wr_sel %h", bus.wr_sel);

endmodule : agc_register_file

/* src/agc_sequencer.sv */
`timescale 1ns/1ns

module agc_sequencer (
  input  logic clk,
  input  logic rst_l,
  input  logic cmd_valid,
  input  agc_pkg::cmd_op_t cmd_op,
  input  agc_pkg::reg_t cmd_reg,
  input  agc_pkg::word_t cmd_data,
  input  agc_pkg::addr_t cmd_addr,
  agc_reg_if.seq reg_bus,
  agc_alu_if.seq alu_bus,
  output agc_pkg::addr_t xlate_addr,
  input  agc_pkg::rom_addr_t xlate_rom,
  input  agc_pkg::ram_addr_t xlate_ram,
  input  logic xlate_is_rom,
  output logic rsp_valid,
  output agc_pkg::word_t rsp_data,
  output agc_pkg::rom_addr_t rom_addr,
  output agc_pkg::ram_addr_t ram_addr,
  output logic addr_is_rom
);
  import agc_pkg::*;

  logic wr_req;
  reg_t wr_target;
  word_t wr_value;
  word_t rsp_next;
  logic xlate_hit;

  // Operand B is always the view of cmd_reg
  assign reg_bus.rd_sel = cmd_reg;
  assign alu_bus.x = reg_bus.acc;
  assign alu_bus.y = reg_bus.rd_data;

  // Translator sees the raw program address
  assign xlate_addr = cmd_addr;

  // Opcode to ALU operation
  always_comb begin
    alu_bus.op = ALU_AD;
    case (cmd_op)
      CMD_SU: alu_bus.op = ALU_SU;
      CMD_AND: alu_bus.op = ALU_AND;
      CMD_OR: alu_bus.op = ALU_OR;
      CMD_XOR: alu_bus.op = ALU_XOR;
      CMD_COM: alu_bus.op = ALU_COM;
      CMD_INCR: alu_bus.op = ALU_INCR;
      // AD, and don't care for non-ALU commands
      default: alu_bus.op = ALU_AD;
    endcase
  end

  // Write target and response word
  always_comb begin
    wr_req = 1'b0;
    wr_target = cmd_reg;
    wr_value = cmd_data;
    // READ and WRITE answer with the old view
    rsp_next = reg_bus.rd_data;
    case (cmd_op)
      CMD_WRITE: wr_req = 1'b1;
      // Two-operand ops always land in A
      CMD_AD, CMD_SU, CMD_AND, CMD_OR, CMD_XOR: begin
        wr_req = 1'b1;
        wr_target = A;
        wr_value = alu_bus.result;
        rsp_next = alu_bus.result;
      end
      // Single-operand ops go back where they came from
      CMD_COM, CMD_INCR: begin
        wr_req = 1'b1;
        wr_value = alu_bus.result;
        rsp_next = alu_bus.result;
      end
      CMD_XLATE: rsp_next = '0;
      default: rsp_next = reg_bus.rd_data;
    endcase
  end

  // ZERO is never written
  assign reg_bus.wr_en = cmd_valid && wr_req && (wr_target != ZERO);
  assign reg_bus.wr_sel = wr_target;
  assign reg_bus.wr_data = wr_value;

  assign xlate_hit = cmd_valid && (cmd_op == CMD_XLATE);

  // Response strobe and data, one cycle after the command
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      rsp_valid <= 1'b0;
      rsp_data <= '0;
    end else begin
      rsp_valid <= cmd_valid;
      if (cmd_valid) begin
        rsp_data <= rsp_next;
      end
    end
  end

  // Physical addresses hold until the next XLATE
  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      rom_addr <= '0;
      ram_addr <= '0;
      addr_is_rom <= 1'b0;
    end else if (xlate_hit) begin
      rom_addr <= xlate_rom;
      ram_addr <= xlate_ram;
      addr_is_rom <= xlate_is_rom;
    end
  end

  // One response per command, exactly one cycle later
  a_rsp_after_cmd: assert property (@(posedge clk) disable iff (!rst_l)
    cmd_valid |=> rsp_valid)
    else $error("rsp_valid missing after cmd_valid");

  a_no_rsp_without_cmd: assert property (@(posedge clk) disable iff (!rst_l)
    !cmd_valid |=> !rsp_valid)
    else $error("rsp_valid without a command");

  // Register file has no storage behind ZERO
  a_no_zero_write: assert property (@(posedge clk) disable iff (!rst_l)
    reg_bus.wr_en |-> (reg_bus.wr_sel != ZERO))
    else $error("write aimed at ZERO");

endmodule : agc_sequencer

/* src/agc_settings.svh */
`ifndef AGC_SETTINGS_SVH
`define AGC_SETTINGS_SVH

// Machine word, sign in bit 14
`define AGC_WORD_W 15

// Program address as seen by software
`define AGC_ADDR_W 12

// Physical memory address widths
`define AGC_ROM_ADDR_W 14
`define AGC_RAM_ADDR_W 11

// EB and FB bank number width
`define AGC_BANK_W 3

// Memory map, octal like the original documentation
`define AGC_FIXED_SWITCH_BASE 'o2000
`define AGC_FIXED_FIXED_BASE 'o4000
`define AGC_ERASABLE_BANK_BASE 'o1400
`define AGC_ERASABLE_BANK_SIZE 'o400
`define AGC_FIXED_BANK_SIZE 'o2000

`endif

/* tests/agc_core_tb.sv */
`timescale 1ns/1ns
`include "agc_settings.svh"

module agc_core_tb;
  import agc_pkg::*;

  localparam int RESET_CYCLES = 10;
  // Reset, about 630 commands, phase gaps and drain, plus margin
  localparam int TIMEOUT_CYCLES = 900;

  typedef struct packed {
    word_t rsp;
    rom_addr_t rom;
    ram_addr_t ram;
    logic is_rom;
  } expect_t;

  logic clk;
  logic rst_l;
  logic cmd_valid;
  cmd_op_t cmd_op;
  reg_t cmd_reg;
  word_t cmd_data;
  addr_t cmd_addr;
  logic rsp_valid;
  word_t rsp_data;
  rom_addr_t rom_addr;
  ram_addr_t ram_addr;
  logic addr_is_rom;

  // Shadow register state of the model
  word_t regs_m [0:12];
  bank_t eb_m;
  bank_t fb_m;
  rom_addr_t held_rom;
  ram_addr_t held_ram;
  logic held_is_rom;

  expect_t exp_q [$];
  expect_t cur;
  int cycle_count;

  agc_core uut (
    .clk(clk),
    .rst_l(rst_l),
    .cmd_valid(cmd_valid),
    .cmd_op(cmd_op),
    .cmd_reg(cmd_reg),
    .cmd_data(cmd_data),
    .cmd_addr(cmd_addr),
    .rsp_valid(rsp_valid),
    .rsp_data(rsp_data),
    .rom_addr(rom_addr),
    .ram_addr(ram_addr),
    .addr_is_rom(addr_is_rom)
  );

  always #2 clk = ~clk;

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic show_mismatch(string name, logic [31:0] got, logic [31:0] want);
    abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, want));
  endtask

  // Read view as the architecture defines it
  function automatic word_t view_of(reg_t r);
    case (r)
      EB: return word_t'(eb_m) << 9;
      FB: return word_t'(fb_m) << 12;
      BB: return (word_t'(fb_m) << 12) | (word_t'(eb_m) << 9);
      ZERO: return '0;
      default: return regs_m[r];
    endcase
  endfunction

  // Write shaping, editing registers store the shifted word
  function automatic void store_word(reg_t r, word_t w);
    case (r)
      EB: eb_m = w[11:9];
      FB: fb_m = w[14:12];
      BB: begin
        fb_m = w[14:12];
        eb_m = w[11:9];
      end
      ZERO: begin
      end
      CYR: regs_m[r] = (w >> 1) | ((w & 1) << 14);
      SR: regs_m[r] = (w >> 1) | (w & 15'h4000);
      CYL: regs_m[r] = (w << 1) | (w >> 14);
      SL: regs_m[r] = w << 1;
      default: regs_m[r] = w;
    endcase
  endfunction

  // Ones' complement add, overflow past 2^15 wraps to bit 0
  function automatic word_t oc_add(word_t a, word_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 'h7fff) s = s - 'h8000 + 1;
    return word_t'(s);
  endfunction

  // Reference model, one command against the shadow state
  function automatic expect_t predict(cmd_op_t op, reg_t r, word_t d, addr_t a);
    expect_t e;
    word_t y;
    word_t res;
    int ad;
    y = view_of(r);
    ad = a;
    e.rsp = y;
    res = '0;
    case (op)
      CMD_WRITE: store_word(r, d);
      CMD_AD: res = oc_add(regs_m[A], y);
      CMD_SU: res = oc_add(regs_m[A], ~y);
      CMD_AND: res = regs_m[A] & y;
      CMD_OR: res = regs_m[A] | y;
      CMD_XOR: res = regs_m[A] ^ y;
      CMD_COM: res = ~y;
      CMD_INCR: res = oc_add(y, 15'd1);
      CMD_XLATE: begin
        e.rsp = '0;
        held_rom = '0;
        held_ram = '0;
        held_is_rom = ad >= `AGC_FIXED_SWITCH_BASE;
        if (ad >= `AGC_FIXED_FIXED_BASE)
          held_rom = ad - `AGC_FIXED_FIXED_BASE;
        else if (ad >= `AGC_FIXED_SWITCH_BASE)
          held_rom = `AGC_FIXED_FIXED_BASE + fb_m * `AGC_FIXED_BANK_SIZE
                   + (ad - `AGC_FIXED_SWITCH_BASE);
        else if (ad >= `AGC_ERASABLE_BANK_BASE)
          held_ram = eb_m * `AGC_ERASABLE_BANK_SIZE + (ad - `AGC_ERASABLE_BANK_BASE);
        else
          held_ram = ad;
      end
      default: begin
      end
    endcase
    // Two-operand results land in A
    if (op inside {CMD_AD, CMD_SU, CMD_AND, CMD_OR, CMD_XOR}) begin
      store_word(A, res);
      e.rsp = res;
    end
    if (op inside {CMD_COM, CMD_INCR}) begin
      store_word(r, res);
      e.rsp = res;
    end
    e.rom = held_rom;
    e.ram = held_ram;
    e.is_rom = held_is_rom;
    return e;
  endfunction

  // Words biased toward plus and minus zero
  function automatic word_t rand_word();
    case ($urandom_range(7, 0))
      0: return '0;
      1: return 15'h7fff;
      default: return word_t'($urandom);
    endcase
  endfunction

  function automatic addr_t rand_addr(int region);
    case (region)
      0: return addr_t'($urandom_range('o1377, 0));
      1: return addr_t'($urandom_range('o1777, 'o1400));
      2: return addr_t'($urandom_range('o3777, 'o2000));
      default: return addr_t'($urandom_range('o7777, 'o4000));
    endcase
  endfunction

  task automatic send(cmd_op_t op, reg_t r, word_t d, addr_t a);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_reg = r;
    cmd_data = d;
    cmd_addr = a;
    exp_q.push_back(predict(op, r, d, a));
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(negedge clk);
      cmd_valid = 1'b0;
    end
  endtask

  // Responses are stable at the falling edge
  always @(negedge clk) begin
    if (rst_l && rsp_valid) begin
      assert (exp_q.size() > 0)
        else abort_run("response arrived with no command pending");
      cur = exp_q.pop_front();
      assert (rsp_data === cur.rsp)
        else show_mismatch("rsp_data", rsp_data, cur.rsp);
      assert (rom_addr === cur.rom)
        else show_mismatch("rom_addr", rom_addr, cur.rom);
      assert (ram_addr === cur.ram)
        else show_mismatch("ram_addr", ram_addr, cur.ram);
      assert (addr_is_rom === cur.is_rom)
        else show_mismatch("addr_is_rom", addr_is_rom, cur.is_rom);
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run("timeout, responses stopped before all commands were answered");
  end

  initial begin
    void'($urandom(32'h6eae));
    clk = 1'b0;
    rst_l = 1'b0;
    cmd_valid = 1'b0;
    cmd_op = CMD_READ;
    cmd_reg = A;
    cmd_data = '0;
    cmd_addr = '0;
    cycle_count = 0;
    foreach (regs_m[i]) regs_m[i] = '0;
    eb_m = '0;
    fb_m = '0;
    held_rom = '0;
    held_ram = '0;
    held_is_rom = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_l = 1'b1;
    assert (rom_addr === '0 && ram_addr === '0 && addr_is_rom === 1'b0)
      else abort_run("address outputs not cleared by reset");

    // Every register reads zero out of reset
    for (int i = 0; i < 13; i++) send(CMD_READ, reg_t'(i), '0, '0);
    idle(2);

    // Write then read back each register view
    for (int i = 0; i < 13; i++) begin
      send(CMD_WRITE, reg_t'(i), word_t'($urandom), '0);
      send(CMD_READ, reg_t'(i), '0, '0);
    end
    idle(2);

    // Carry out wraps around
    send(CMD_WRITE, A, 15'h6000, '0);
    send(CMD_WRITE, Q, 15'h5000, '0);
    send(CMD_AD, Q, '0, '0);
    send(CMD_WRITE, A, 15'h0005, '0);
    send(CMD_WRITE, L, 15'h0003, '0);
    send(CMD_SU, L, '0, '0);
    send(CMD_WRITE, A, 15'h7fff, '0);
    send(CMD_AD, ZERO, '0, '0);
    for (int i = 0; i < 24; i++) begin
      send(CMD_WRITE, A, rand_word(), '0);
      send(CMD_WRITE, reg_t'($urandom_range(12, 0)), rand_word(), '0);
      send(($urandom_range(1, 0) == 0) ? CMD_AD : CMD_SU,
           reg_t'($urandom_range(12, 0)), '0, '0);
    end
    idle(2);

    // Logic and single-operand ops, ZERO stays zero
    send(CMD_WRITE, ZERO, 15'h5555, '0);
    send(CMD_READ, ZERO, '0, '0);
    send(CMD_COM, ZERO, '0, '0);
    for (int i = 0; i < 30; i++) begin
      send(CMD_WRITE, reg_t'($urandom_range(12, 0)), rand_word(), '0);
      send(cmd_op_t'($urandom_range(CMD_INCR, CMD_AND)),
           reg_t'($urandom_range(12, 0)), '0, '0);
    end
    idle(2);

    // Bank translation, region edges then random banks
    send(CMD_XLATE, A, '0, 12'o0000);
    send(CMD_XLATE, A, '0, 12'o1377);
    send(CMD_XLATE, A, '0, 12'o1400);
    send(CMD_XLATE, A, '0, 12'o1777);
    send(CMD_XLATE, A, '0, 12'o2000);
    send(CMD_XLATE, A, '0, 12'o3777);
    send(CMD_XLATE, A, '0, 12'o4000);
    send(CMD_XLATE, A, '0, 12'o7777);
    for (int i = 0; i < 20; i++) begin
      send(CMD_WRITE, BB, word_t'($urandom), '0);
      send(CMD_XLATE, A, '0, rand_addr(i % 4));
    end
    idle(2);

    // Back-to-back random stream
    for (int i = 0; i < 400; i++) begin
      send(cmd_op_t'($urandom_range(CMD_XLATE, CMD_WRITE)),
           reg_t'($urandom_range(12, 0)), rand_word(), rand_addr($urandom_range(3, 0)));
    end
    idle(1);

    // Drain, then watch a few idle cycles for stray responses
    while (exp_q.size() != 0) @(negedge clk);
    idle(3);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule : agc_core_tb
